//--- tb.f
+incdir+source
source/cpu_isa_pkg.sv
source/cpu_core_pkg.sv
source/reg_read_if.sv
source/reg_bank.sv
source/alu.sv
source/cpu_sequencer.sv
source/cpu_top.sv
test/tb_clock_gen.sv
test/tb_memory.sv
test/tb_cpu.sv

//--- test/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
();

    localparam int MAX_TESTS  = 24;
    localparam int MAX_STORES = 4;
    localparam int PROG_WORDS = 8;

    logic  clock;
    logic  rst_n;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_we;
    logic  halted;

    string  test_name [MAX_TESTS];
    int     test_exec [MAX_TESTS];
    instr_t test_prog [MAX_TESTS][PROG_WORDS];
    int     test_nst [MAX_TESTS];
    word_t  test_st_addr [MAX_TESTS][MAX_STORES];
    word_t  test_st_data [MAX_TESTS][MAX_STORES];

    int     n_tests       = 0;
    int     errors        = 0;
    int     failed_tests  = 0;
    int     cycle_total   = 0;
    int     timeout_limit = 0;
    integer seed          = 92;

    tb_clock_gen i_clk (
        .clock (clock),
        .rst_n (rst_n)
    );

    tb_memory i_mem (
        .clock (clock),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

    cpu_top i_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .halted    (halted)
    );

    function automatic instr_t make_instr(input opcode_t op, input int dst, input int a,
                                          input int b, input bit hl, input imm_t imm);
        instr_t w;
        w.opcode = op;
        w.src_a  = sel_t'(a);
        w.src_b  = sel_t'(b);
        w.dst    = sel_t'(dst);
        w.hl     = hl;
        w.imm    = imm;
        return w;
    endfunction

    function automatic instr_t ldi(input int dst, input imm_t imm, input bit hl);
        return make_instr(OP_LDI, dst, 0, 0, hl, imm);
    endfunction

    function automatic instr_t reg_reg(input opcode_t op, input int dst, input int a, input int b);
        return make_instr(op, dst, a, b, 1'b0, '0);
    endfunction

    // value from src_a goes to the address held in src_b
    function automatic instr_t store_word(input int value_reg, input int addr_reg);
        return make_instr(OP_STORE, 0, value_reg, addr_reg, 1'b0, '0);
    endfunction

    function automatic instr_t branch(input opcode_t op, input int flag_reg, input int target);
        return make_instr(op, 0, flag_reg, 0, 1'b0, imm_t'(target));
    endfunction

    function automatic instr_t no_operands(input opcode_t op);
        return make_instr(op, 0, 0, 0, 1'b0, '0);
    endfunction

    task automatic add_test(input string name, input int executed,
                            input instr_t p0, input instr_t p1, input instr_t p2,
                            input instr_t p3, input instr_t p4, input instr_t p5,
                            input instr_t p6, input instr_t p7);
        test_name[n_tests]    = name;
        test_exec[n_tests]    = executed;
        test_nst[n_tests]     = 0;
        test_prog[n_tests][0] = p0;
        test_prog[n_tests][1] = p1;
        test_prog[n_tests][2] = p2;
        test_prog[n_tests][3] = p3;
        test_prog[n_tests][4] = p4;
        test_prog[n_tests][5] = p5;
        test_prog[n_tests][6] = p6;
        test_prog[n_tests][7] = p7;
        n_tests++;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        test_st_addr[n_tests-1][test_nst[n_tests-1]] = addr;
        test_st_data[n_tests-1][test_nst[n_tests-1]] = data;
        test_nst[n_tests-1]++;
    endtask

    task automatic build_table();
        word_t ra;
        word_t rb;
        word_t a;
        word_t b;
        add_test("add_sub", 8,
            ldi(1, 16'hABCD, 1), ldi(2, 16'h9876, 0), ldi(7, 16'h0040, 0),
            reg_reg(OP_ADD, 3, 1, 2), reg_reg(OP_SUB, 4, 2, 1), store_word(3, 7),
            store_word(4, 7), no_operands(OP_HALT));
        expect_store(32'h40, 32'hABCD0000 + 32'h00009876);
        expect_store(32'h40, 32'h00009876 - 32'hABCD0000);
        add_test("and_or", 8,
            ldi(1, 16'hF0F0, 0), ldi(2, 16'h33CC, 0), ldi(7, 16'h0041, 0),
            reg_reg(OP_AND, 3, 1, 2), reg_reg(OP_OR, 4, 1, 2), store_word(3, 7),
            store_word(4, 7), no_operands(OP_HALT));
        expect_store(32'h41, 32'h0000F0F0 & 32'h000033CC);
        expect_store(32'h41, 32'h0000F0F0 | 32'h000033CC);
        add_test("xor", 6,
            ldi(1, 16'h5A5A, 1), ldi(2, 16'hA5A5, 0), ldi(7, 16'h0042, 0),
            reg_reg(OP_XOR, 3, 1, 2), store_word(3, 7), no_operands(OP_HALT),
            no_operands(OP_NOP), no_operands(OP_NOP));
        expect_store(32'h42, 32'h5A5A0000 ^ 32'h0000A5A5);
        // immediate of ADDI is zero extended
        add_test("ldi_addi", 8,
            ldi(1, 16'hBEEF, 1), ldi(2, 16'h8001, 0), make_instr(OP_ADDI, 3, 1, 0, 0, 16'hFFFF),
            ldi(7, 16'h0044, 0), store_word(1, 7), store_word(2, 7),
            store_word(3, 7), no_operands(OP_HALT));
        expect_store(32'h44, 32'hBEEF0000);
        expect_store(32'h44, 32'h00008001);
        expect_store(32'h44, 32'hBEEF0000 + 32'h0000FFFF);
        add_test("jf_taken", 7,
            ldi(1, 16'h0005, 0), ldi(2, 16'h0009, 0), ldi(7, 16'h0048, 0),
            reg_reg(OP_CMPLT, 3, 1, 2), branch(OP_JF, 3, 6), store_word(1, 7),
            store_word(3, 7), no_operands(OP_HALT));
        expect_store(32'h48, 32'h5);
        // 0x80000000 is not below 5 when compared unsigned
        add_test("jf_not_taken", 8,
            ldi(1, 16'h8000, 1), ldi(2, 16'h0005, 0), ldi(7, 16'h0049, 0),
            reg_reg(OP_CMPLT, 3, 1, 2), branch(OP_JF, 3, 6), store_word(1, 7),
            store_word(3, 7), no_operands(OP_HALT));
        expect_store(32'h49, 32'h80000000);
        expect_store(32'h49, 32'h80000000);
        add_test("zero_flag", 6,
            ldi(1, 16'h1234, 0), ldi(7, 16'h004A, 0), reg_reg(OP_SUB, 3, 1, 1),
            branch(OP_JF, 3, 5), store_word(1, 7), store_word(3, 7),
            no_operands(OP_HALT), no_operands(OP_NOP));
        expect_store(32'h4A, 32'h0);
        add_test("jmp_over_store", 6,
            ldi(1, 16'h0077, 0), ldi(7, 16'h0050, 0), branch(OP_JMP, 0, 4),
            store_word(1, 7), make_instr(OP_ADDI, 2, 1, 0, 0, 16'h0001), store_word(2, 7),
            no_operands(OP_HALT), no_operands(OP_NOP));
        expect_store(32'h50, 32'h78);
        add_test("timing", 6,
            no_operands(OP_NOP), no_operands(OP_NOP), ldi(1, 16'hC0DE, 1),
            ldi(7, 16'h0054, 0), store_word(1, 7), no_operands(OP_HALT),
            no_operands(OP_NOP), no_operands(OP_NOP));
        expect_store(32'h54, 32'hC0DE0000);
        add_test("halt_only", 1,
            no_operands(OP_HALT), no_operands(OP_NOP), no_operands(OP_NOP),
            no_operands(OP_NOP), no_operands(OP_NOP), no_operands(OP_NOP),
            no_operands(OP_NOP), no_operands(OP_NOP));
        // bit 16 of each draw picks the half that LDI fills
        for (int k = 0; k < 10; k++)
        begin
            ra = $random(seed);
            rb = $random(seed);
            a  = ra[16] ? {ra[15:0], 16'h0000} : {16'h0000, ra[15:0]};
            b  = rb[16] ? {rb[15:0], 16'h0000} : {16'h0000, rb[15:0]};
            add_test($sformatf("random_%0d", k), 8,
                ldi(1, ra[15:0], ra[16]), ldi(2, rb[15:0], rb[16]), ldi(5, imm_t'(16'h60 + k), 0),
                reg_reg(OP_ADD, 3, 1, 2), reg_reg(OP_XOR, 4, 1, 2), store_word(3, 5),
                store_word(4, 5), no_operands(OP_HALT));
            expect_store(word_t'(32'h60 + k), a + b);
            expect_store(word_t'(32'h60 + k), a ^ b);
        end
    endtask

    task automatic compare_word(input string name, input string what,
                                input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("[FAIL] %s cycles to halt: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int errors_before;
        int cycles;
        int n_check;
        errors_before = errors;
        i_mem.clear_mem();
        for (int i = 0; i < PROG_WORDS; i++)
        begin
            i_mem.write_word(i, word_t'(test_prog[t][i]));
        end
        i_mem.clear_log();
        i_clk.apply_reset();
        // cycle 1 is the first FETCH, the one in which reset is released
        cycles = 1;
        while (halted !== 1'b1)
        begin
            @(negedge clock);
            cycles++;
        end
        compare_count(test_name[t], 3 * test_exec[t], cycles);
        n_check = test_nst[t];
        if (i_mem.log_count != test_nst[t])
        begin
            $display("%s: the DUT made %0d stores but %0d were expected",
                     test_name[t], i_mem.log_count, test_nst[t]);
            errors++;
            if (i_mem.log_count < n_check)
            begin
                n_check = i_mem.log_count;
            end
        end
        for (int k = 0; k < n_check; k++)
        begin
            compare_word(test_name[t], $sformatf("store %0d address", k),
                         test_st_addr[t][k], i_mem.log_addr[k]);
            compare_word(test_name[t], $sformatf("store %0d data", k),
                         test_st_data[t][k], i_mem.log_data[k]);
        end
        if (errors == errors_before)
        begin
            $display("[PASS] %s", test_name[t]);
        end
        else
        begin
            $display("test %s failed with %0d errors", test_name[t], errors - errors_before);
            failed_tests++;
        end
    endtask

    initial
    begin
        int total_exec;
        total_exec = 0;
        build_table();
        for (int t = 0; t < n_tests; t++)
        begin
            total_exec += test_exec[t];
        end
        timeout_limit = 3 * total_exec + 12 * n_tests + 50;
        for (int t = 0; t < n_tests; t++)
        begin
            run_test(t);
        end
        $display("tests run: %0d, passed: %0d, failed: %0d",
                 n_tests, n_tests - failed_tests, failed_tests);
        if (errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial
    begin
        wait (timeout_limit > 0);
        while (cycle_total < timeout_limit)
        begin
            @(posedge clock);
            cycle_total++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", timeout_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory
    import cpu_core_pkg::*;
#(
    parameter int DEPTH     = 256,
    parameter int LOG_DEPTH = 16
)
(
    input  wire logic  clock,
    input  wire word_t addr,
    input  wire word_t wdata,
    input  wire logic  we,
    output word_t      rdata
);

    word_t mem [DEPTH];
    word_t log_addr [LOG_DEPTH];
    word_t log_data [LOG_DEPTH];
    int    log_count = 0;

    // word addressed, upper address bits alias onto the array
    assign rdata = mem[addr % DEPTH];

    always @(posedge clock)
    begin
        if (we)
        begin
            mem[addr % DEPTH] <= wdata;
            if (log_count < LOG_DEPTH)
            begin
                log_addr[log_count] = addr;
                log_data[log_count] = wdata;
            end
            log_count = log_count + 1;
        end
    end

    // empty words read as NOP
    task automatic clear_mem();
        for (int i = 0; i < DEPTH; i++)
        begin
            mem[i] = '0;
        end
    endtask

    task automatic write_word(input int index, input word_t data);
        mem[index % DEPTH] = data;
    endtask

    task automatic clear_log();
        log_count = 0;
    endtask

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic clock,
    output logic rst_n
);

    // 4 ns period
    initial
    begin
        clock = 1'b0;
        rst_n = 1'b0;
        forever #2 clock = ~clock;
    end

    // reset moves on the falling edge and stays low for 10 cycles
    task automatic apply_reset();
        @(negedge clock);
        rst_n = 1'b0;
        repeat (10) @(negedge clock);
        rst_n = 1'b1;
    endtask

endmodule

`default_nettype wire

//--- source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire word_t mem_rdata,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic       mem_we,
    output logic       halted
);

    instr_t instr;
    logic   exec;
    word_t  result;
    flag_t  result_flag;
    logic   write_en;
    logic   branch_taken;
    word_t  branch_target;
    logic   store;
    logic   halt;

    reg_read_if rd_if ();

    // store writes word A to the address held in word B
    cpu_sequencer i_seq (
        .clock         (clock),
        .rst_n         (rst_n),
        .mem_rdata     (mem_rdata),
        .write_en      (write_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .store         (store),
        .halt          (halt),
        .store_data    (rd_if.word_a),
        .store_addr    (rd_if.word_b),
        .instr         (instr),
        .exec          (exec),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_we        (mem_we),
        .halted        (halted)
    );

    alu i_alu (
        .instr         (instr),
        .exec          (exec),
        .read          (rd_if),
        .result        (result),
        .result_flag   (result_flag),
        .write_en      (write_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .store         (store),
        .halt          (halt)
    );

    reg_bank #(
        .entry_t      (word_t),
        .is_flag_bank (1'b0)
    ) i_word_bank (
        .clock      (clock),
        .rst_n      (rst_n),
        .read       (rd_if),
        .write_en   (write_en),
        .write_sel  (instr.dst),
        .write_data (result)
    );

    reg_bank #(
        .entry_t      (flag_t),
        .is_flag_bank (1'b1)
    ) i_flag_bank (
        .clock      (clock),
        .rst_n      (rst_n),
        .read       (rd_if),
        .write_en   (write_en),
        .write_sel  (instr.dst),
        .write_data (result_flag)
    );

endmodule

`default_nettype wire

//--- source/cpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire word_t mem_rdata,
    input  wire logic  write_en,
    input  wire logic  branch_taken,
    input  wire word_t branch_target,
    input  wire logic  store,
    input  wire logic  halt,
    input  wire word_t store_data,
    input  wire word_t store_addr,
    output instr_t     instr,
    output logic       exec,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic       mem_we,
    output logic       halted
);

    seq_state_t state;
    word_t      pc;
    word_t      target_q;
    instr_t     ir;
    logic       taken_q;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state   <= FETCH;
            pc      <= '0;
            taken_q <= 1'b0;
            halted  <= 1'b0;
        end
        else
        begin
            case (state)
                FETCH:
                begin
                    state <= EXEC;
                end
                EXEC:
                begin
                    taken_q <= branch_taken;
                    if (halt)
                    begin
                        halted <= 1'b1;
                    end
                    state <= UPDATE;
                end
                UPDATE:
                begin
                    // once halted, park here with the pc frozen
                    if (!halted)
                    begin
                        pc    <= taken_q ? target_q : pc + word_t'(1);
                        state <= FETCH;
                    end
                end
                default:
                begin
                    state <= FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == FETCH)
        begin
            ir <= instr_t'(mem_rdata);
        end
        if (state == EXEC && branch_taken)
        begin
            target_q <= branch_target;
        end
    end

    assign instr     = ir;
    assign exec      = (state == EXEC);
    // store already carries the exec qualifier from the alu
    assign mem_we    = store;
    assign mem_addr  = store ? store_addr : pc;
    assign mem_wdata = store_data;

    state_legal: assert property (
        @(posedge clock) disable iff (!rst_n)
        state inside {FETCH, EXEC, UPDATE}
    ) else $error("sequencer state left the legal encodings");

    // memory and register writes both belong to the execute cycle
    write_only_in_exec: assert property (
        @(posedge clock) disable iff (!rst_n)
        (mem_we || write_en) |-> (state == EXEC)
    ) else $error("write outside EXEC");

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
(
    input  wire instr_t  instr,
    input  wire logic    exec,
    reg_read_if.reader   read,
    output word_t        result,
    output flag_t        result_flag,
    output logic         write_en,
    output logic         branch_taken,
    output word_t        branch_target,
    output logic         store,
    output logic         halt
);

    word_t a_word;
    word_t b_word;
    word_t imm_ext;
    word_t res;
    flag_t a_flag;
    logic  wr;
    logic  is_cmp;
    logic  take;
    logic  st;
    logic  hlt;

    assign read.sel_a = instr.src_a;
    assign read.sel_b = instr.src_b;

    assign a_word  = read.word_a;
    assign b_word  = read.word_b;
    assign a_flag  = read.flag_a;
    assign imm_ext = word_t'(instr.imm);

    always_comb
    begin
        res    = '0;
        wr     = 1'b0;
        is_cmp = 1'b0;
        take   = 1'b0;
        st     = 1'b0;
        hlt    = 1'b0;
        case (instr.opcode)
            OP_ADD:   begin res = a_word + b_word; wr = 1'b1; end
            OP_SUB:   begin res = a_word - b_word; wr = 1'b1; end
            OP_AND:   begin res = a_word & b_word; wr = 1'b1; end
            OP_OR:    begin res = a_word | b_word; wr = 1'b1; end
            OP_XOR:   begin res = a_word ^ b_word; wr = 1'b1; end
            OP_ADDI:  begin res = a_word + imm_ext; wr = 1'b1; end
            OP_LDI:
            begin
                // hl selects the upper half and the other half stays zero
                res = instr.hl ? {instr.imm, 16'h0000} : imm_ext;
                wr  = 1'b1;
            end
            OP_CMPLT:
            begin
                res    = a_word;
                is_cmp = 1'b1;
                wr     = 1'b1;
            end
            OP_JMP:   take = 1'b1;
            OP_JF:    take = a_flag;
            OP_STORE: st   = 1'b1;
            OP_HALT:  hlt  = 1'b1;
            default:  res  = '0;
        endcase
    end

    // CMPLT flags an unsigned A below B and other opcodes flag a zero result
    assign result      = res;
    assign result_flag = is_cmp ? flag_t'(a_word < b_word) : flag_t'(res == '0);

    assign write_en      = exec & wr;
    assign store         = exec & st;
    assign halt          = exec & hlt;
    assign branch_taken  = take;
    assign branch_target = imm_ext;

endmodule

`default_nettype wire

//--- source/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module reg_bank
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
#(
    parameter type entry_t      = word_t,
    parameter bit  is_flag_bank = 1'b0
)
(
    input  wire logic   clock,
    input  wire logic   rst_n,
    reg_read_if.bank    read,
    input  wire logic   write_en,
    input  wire sel_t   write_sel,
    input  wire entry_t write_data
);

    entry_t entries [`CPU_NUM_REGS];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (write_en)
        begin
            entries[write_sel] <= write_data;
        end
    end

    // both read ports are combinational
    // each instance fills only its own pair of fields in the shared interface
    generate
        if (is_flag_bank)
        begin : g_flag_read
            assign read.flag_a = entries[read.sel_a];
            assign read.flag_b = entries[read.sel_b];
        end
        else
        begin : g_word_read
            assign read.word_a = entries[read.sel_a];
            assign read.word_b = entries[read.sel_b];
        end
    endgenerate

    // destination comes straight from the instruction register
    write_sel_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        write_en |-> !$isunknown(write_sel)
    ) else $error("reg_bank write with unknown select");

endmodule

`default_nettype wire

//--- source/reg_read_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_read_if
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;
();

    sel_t  sel_a;
    sel_t  sel_b;
    word_t word_a;
    word_t word_b;
    flag_t flag_a;
    flag_t flag_b;

    // alu side picks the sources
    modport reader (
        output sel_a,
        output sel_b,
        input  word_a,
        input  word_b,
        input  flag_a,
        input  flag_b
    );

    // word bank fills word_*, flag bank fills flag_*
    modport bank (
        input  sel_a,
        input  sel_b,
        output word_a,
        output word_b,
        output flag_a,
        output flag_b
    );

endinterface

`default_nettype wire

//--- source/cpu_core_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_core_pkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;

    typedef logic flag_t;

    // one instruction walks through all three states
    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        EXEC   = 2'd1,
        UPDATE = 2'd2
    } seq_state_t;

endpackage

`default_nettype wire

//--- source/cpu_isa_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_SEL_WIDTH-1:0] sel_t;

    typedef logic [15:0] imm_t;

    // opcode values not listed here execute as NOP
    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_ADDI  = 6'd6,
        OP_STORE = 6'd7,
        OP_LDI   = 6'd8,
        OP_CMPLT = 6'd9,
        OP_JMP   = 6'd10,
        OP_JF    = 6'd11,
        OP_HALT  = 6'd63
    } opcode_t;

    // msb first: imm 31:16, hl 15, dst 14:12, src_b 11:9, src_a 8:6, opcode 5:0
    typedef struct packed {
        imm_t    imm;
        logic    hl;
        sel_t    dst;
        sel_t    src_b;
        sel_t    src_a;
        opcode_t opcode;
    } instr_t;

endpackage

`default_nettype wire

//--- source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define CPU_WORD_WIDTH 32

// general registers, one flag per register
`define CPU_NUM_REGS 8

// register select width, log2 of CPU_NUM_REGS
`define CPU_SEL_WIDTH 3

`endif
